// ==== Bender.yml ====
package:
  name: eth_dma

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/eth_dma_pkg.sv
      - rtl/eth_dma_apb_regs.sv
      - rtl/eth_burst_split.sv
      - rtl/eth_dma_axi_writer.sv
      - rtl/eth_dma_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/eth_dma_tb.sv

// ==== include/eth_dma_macros.svh ====
`ifndef ETH_DMA_MACROS_SVH
`define ETH_DMA_MACROS_SVH

// APB register byte offsets
`define ETH_DMA_ADDR_REG 12'h000
`define ETH_DMA_LEN_REG  12'h004
`define ETH_DMA_CTRL_REG 12'h008
`define ETH_DMA_STAT_REG 12'h00C

// data path word, also the AXI beat and APB data width
`define ETH_DMA_DATA_W 32

// frame length field, 1 to 1023 bytes
// offset plus length must stay within 1024 bytes so the burst fits 256 beats
`define ETH_DMA_LEN_W 10

`endif

// ==== rtl/eth_burst_split.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_dma_macros.svh"

module eth_burst_split #(
    parameter bit no_small_transfer = 1'b0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`ETH_DMA_DATA_W-1:0]    data,
    input  logic                          transfer,
    input  logic [1:0]                    offset,
    input  logic [`ETH_DMA_LEN_W-1:0]     len,
    output logic [`ETH_DMA_DATA_W-1:0]    data_out,
    output logic [`ETH_DMA_DATA_W/8-1:0]  initial_strb,
    output logic [`ETH_DMA_DATA_W/8-1:0]  final_strb,
    output logic [7:0]                    beat_len
);
    localparam int strb_w = `ETH_DMA_DATA_W / 8;
    localparam int off_w  = $clog2(strb_w);

    logic [`ETH_DMA_DATA_W-9:0]     carry;
    logic [2*`ETH_DMA_DATA_W-9:0]   merged;
    logic [off_w-1:0]               skip;
    logic [`ETH_DMA_LEN_W:0]        last_byte;
    logic                           short_len;
    logic [strb_w-1:0]              short_mask;

    // carry keeps the upper three bytes of the previous word, top aligned
    assign merged = {data, carry};
    assign skip   = off_w'(strb_w - 1) - offset;

    // offset 0 passes data straight through, larger offsets pull in carried bytes
    assign data_out = merged[8*skip +: `ETH_DMA_DATA_W];

    // position of the last frame byte counted from the aligned start
    assign last_byte = {1'b0, len} + (`ETH_DMA_LEN_W + 1)'(offset)
                     - (`ETH_DMA_LEN_W + 1)'(1);

    // awlen form, number of beats minus one
    assign beat_len = last_byte[off_w +: 8];

    // the last beat covers bytes 0 up to the final byte lane
    assign final_strb = {strb_w{1'b1}} >> (off_w'(strb_w - 1) - last_byte[off_w-1:0]);

    // a frame shorter than a word may end inside the first beat
    assign short_len = !no_small_transfer && (len < `ETH_DMA_LEN_W'(strb_w));

    always_comb begin
        short_mask = ~({strb_w{1'b1}} << len[off_w:0]);
        if (short_len) begin
            initial_strb = short_mask << offset;
        end else begin
            initial_strb = {strb_w{1'b1}} << offset;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            carry <= '0;
        end else if (transfer) begin
            carry <= data[`ETH_DMA_DATA_W-1:8];
        end
    end

    // short frames are the caller's job to keep out in that build
    a_no_short: assert property (@(posedge clk) disable iff (rst)
        (no_small_transfer && transfer) |-> (len >= `ETH_DMA_LEN_W'(strb_w)));

endmodule

`default_nettype wire

// ==== rtl/eth_dma_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_dma_macros.svh"

module eth_dma_apb_regs #(
    parameter bit no_small_transfer = 1'b0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [11:0]                 paddr,
    input  logic [`ETH_DMA_DATA_W-1:0]  pwdata,
    output logic [`ETH_DMA_DATA_W-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  logic                        busy,
    input  logic                        done_pulse,
    input  eth_dma_pkg::axi_resp_t      done_resp,
    output logic                        start_pulse,
    output logic [`ETH_DMA_DATA_W-1:0]  dma_addr,
    output logic [`ETH_DMA_LEN_W-1:0]   dma_len
);
    import eth_dma_pkg::*;

    logic                       setup;
    logic                       wr_ok;
    logic                       len_bad;
    logic                       acc_err;
    logic [`ETH_DMA_DATA_W-1:0] rd_data;
    logic                       done;
    axi_resp_t                  last_resp;

    // first cycle of an APB transfer
    assign setup = psel && !penable;

    // access cycle of a write that passed the checks
    assign wr_ok = psel && penable && pwrite && !pslverr;

    // zero length is never legal, short ones only when allowed
    assign len_bad = (dma_len == '0)
                  || (no_small_transfer && (dma_len < `ETH_DMA_LEN_W'(4)));

    // decode and error check, evaluated during the setup cycle
    always_comb begin
        acc_err = 1'b0;
        rd_data = '0;
        case (paddr)
            `ETH_DMA_ADDR_REG: begin
                acc_err = pwrite && busy;
                rd_data = dma_addr;
            end
            `ETH_DMA_LEN_REG: begin
                acc_err = pwrite && busy;
                rd_data = {{(`ETH_DMA_DATA_W - `ETH_DMA_LEN_W){1'b0}}, dma_len};
            end
            `ETH_DMA_CTRL_REG: begin
                acc_err = pwrite && (busy || (pwdata[0] && len_bad));
                rd_data = {{(`ETH_DMA_DATA_W - 1){1'b0}}, busy};
            end
            `ETH_DMA_STAT_REG: begin
                // bit 0 done, bits 2:1 last response, bit 3 busy
                rd_data = {{(`ETH_DMA_DATA_W - 4){1'b0}}, busy, last_resp, done};
            end
            default: begin
                acc_err = 1'b1;
            end
        endcase
    end

    // ctrl bit 0 starts the engine
    assign start_pulse = wr_ok && (paddr == `ETH_DMA_CTRL_REG) && pwdata[0];

    // pready and pslverr land in the access cycle, so no wait states
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            pready  <= setup;
            pslverr <= setup && acc_err;
        end
    end

    always_ff @(posedge clk) begin
        if (setup && !pwrite) begin
            prdata <= rd_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dma_addr  <= '0;
            dma_len   <= '0;
            done      <= 1'b0;
            last_resp <= RESP_OKAY;
        end else begin
            if (wr_ok && (paddr == `ETH_DMA_ADDR_REG)) begin
                dma_addr <= pwdata;
            end
            if (wr_ok && (paddr == `ETH_DMA_LEN_REG)) begin
                dma_len <= pwdata[`ETH_DMA_LEN_W-1:0];
            end
            // done is sticky until the next accepted start
            if (start_pulse) begin
                done <= 1'b0;
            end else if (done_pulse) begin
                done      <= 1'b1;
                last_resp <= done_resp;
            end
        end
    end

    // the writer must be idle whenever a start gets through
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        start_pulse |-> !busy);

endmodule

`default_nettype wire

// ==== rtl/eth_dma_axi_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_dma_macros.svh"

module eth_dma_axi_writer #(
    parameter bit no_small_transfer = 1'b0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start_pulse,
    input  logic [`ETH_DMA_DATA_W-1:0]    dma_addr,
    input  logic [`ETH_DMA_LEN_W-1:0]     dma_len,
    output logic                          busy,
    output logic                          done_pulse,
    output eth_dma_pkg::axi_resp_t        done_resp,
    input  logic [`ETH_DMA_DATA_W-1:0]    fifo_data,
    input  logic                          fifo_valid,
    output logic                          fifo_ready,
    output logic [`ETH_DMA_DATA_W-1:0]    awaddr,
    output logic [7:0]                    awlen,
    output logic [2:0]                    awsize,
    output logic [1:0]                    awburst,
    output logic                          awvalid,
    input  logic                          awready,
    output logic [`ETH_DMA_DATA_W-1:0]    wdata,
    output logic [`ETH_DMA_DATA_W/8-1:0]  wstrb,
    output logic                          wlast,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic [1:0]                    bresp,
    input  logic                          bvalid,
    output logic                          bready
);
    import eth_dma_pkg::*;

    localparam int strb_w = `ETH_DMA_DATA_W / 8;
    localparam int off_w  = $clog2(strb_w);
    localparam int cnt_w  = `ETH_DMA_LEN_W - 1;

    wr_state_t                      state;
    logic [`ETH_DMA_DATA_W-1:0]     addr_q;
    logic [`ETH_DMA_LEN_W-1:0]      len_q;
    logic [cnt_w-1:0]               beat_cnt;
    logic [cnt_w-1:0]               word_cnt;
    logic [`ETH_DMA_LEN_W:0]        len_plus3;
    logic [cnt_w-1:0]               word_total;
    logic [cnt_w-1:0]               beat_total;
    logic                           more_beats;
    logic                           need_word;
    logic                           stage_free;
    logic                           load;
    logic                           first_beat;
    logic                           last_beat;
    logic [`ETH_DMA_DATA_W-1:0]     split_in;
    logic [`ETH_DMA_DATA_W-1:0]     split_out;
    logic [strb_w-1:0]              initial_strb;
    logic [strb_w-1:0]              final_strb;
    logic [7:0]                     beat_len;

    eth_burst_split #(
        .no_small_transfer (no_small_transfer)
    ) u_split (
        .clk          (clk),
        .rst          (rst),
        .data         (split_in),
        .transfer     (load),
        .offset       (addr_q[off_w-1:0]),
        .len          (len_q),
        .data_out     (split_out),
        .initial_strb (initial_strb),
        .final_strb   (final_strb),
        .beat_len     (beat_len)
    );

    // words pulled from the FIFO and beats sent on W
    assign len_plus3  = {1'b0, len_q} + (`ETH_DMA_LEN_W + 1)'(3);
    assign word_total = len_plus3[`ETH_DMA_LEN_W:off_w];
    assign beat_total = cnt_w'(beat_len) + cnt_w'(1);

    assign more_beats = (beat_cnt != beat_total);
    assign need_word  = (word_cnt != word_total);
    assign first_beat = (beat_cnt == '0);
    assign last_beat  = (beat_cnt == cnt_w'(beat_len));

    // output stage can take a new beat when empty or draining this cycle
    assign stage_free = !wvalid || wready;

    // the trailing flush beat only drains carried bytes, no FIFO word
    assign load = (state == WR_DATA) && more_beats && stage_free
               && (fifo_valid || !need_word);
    assign fifo_ready = (state == WR_DATA) && need_word && stage_free;
    assign split_in   = need_word ? fifo_data : '0;

    // address channel fields come from the latched job
    assign awaddr  = {addr_q[`ETH_DMA_DATA_W-1:off_w], off_w'(0)};
    assign awlen   = beat_len;
    assign awsize  = 3'(off_w);
    assign awburst = 2'b01;

    assign bready     = (state == WR_RESP);
    assign busy       = (state != WR_IDLE);
    assign done_pulse = bvalid && bready;
    assign done_resp  = axi_resp_t'(bresp);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= WR_IDLE;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            wlast    <= 1'b0;
            beat_cnt <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (start_pulse) begin
                        awvalid <= 1'b1;
                        state   <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (awready) begin
                        awvalid  <= 1'b0;
                        beat_cnt <= '0;
                        word_cnt <= '0;
                        state    <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (load) begin
                        wvalid   <= 1'b1;
                        wlast    <= last_beat;
                        beat_cnt <= beat_cnt + cnt_w'(1);
                        if (need_word) begin
                            word_cnt <= word_cnt + cnt_w'(1);
                        end
                    end else if (wready) begin
                        wvalid <= 1'b0;
                        wlast  <= 1'b0;
                    end
                    if (wvalid && wready && wlast) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (bvalid) begin
                        state <= WR_IDLE;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    // job and beat payload
    always_ff @(posedge clk) begin
        if ((state == WR_IDLE) && start_pulse) begin
            addr_q <= dma_addr;
            len_q  <= dma_len;
        end
        if (load) begin
            wdata <= split_out;
            if (first_beat) begin
                wstrb <= initial_strb;
            end else if (last_beat) begin
                wstrb <= final_strb;
            end else begin
                wstrb <= '1;
            end
        end
    end

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        (state == WR_DATA) && wvalid && !wready
            |=> wvalid && $stable(wdata) && $stable(wstrb) && $stable(wlast));

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen));

endmodule

`default_nettype wire

// ==== rtl/eth_dma_pkg.sv ====
`default_nettype none

package eth_dma_pkg;

    // write engine sequencing
    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_ADDR = 2'd1,
        WR_DATA = 2'd2,
        WR_RESP = 2'd3
    } wr_state_t;

    // AXI B channel response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_t;

endpackage

`default_nettype wire

// ==== rtl/eth_dma_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_dma_macros.svh"

module eth_dma_top #(
    parameter bit no_small_transfer = 1'b0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [11:0]                   paddr,
    input  logic [`ETH_DMA_DATA_W-1:0]    pwdata,
    output logic [`ETH_DMA_DATA_W-1:0]    prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic [`ETH_DMA_DATA_W-1:0]    fifo_data,
    input  logic                          fifo_valid,
    output logic                          fifo_ready,
    output logic [`ETH_DMA_DATA_W-1:0]    awaddr,
    output logic [7:0]                    awlen,
    output logic [2:0]                    awsize,
    output logic [1:0]                    awburst,
    output logic                          awvalid,
    input  logic                          awready,
    output logic [`ETH_DMA_DATA_W-1:0]    wdata,
    output logic [`ETH_DMA_DATA_W/8-1:0]  wstrb,
    output logic                          wlast,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic [1:0]                    bresp,
    input  logic                          bvalid,
    output logic                          bready
);
    import eth_dma_pkg::*;

    logic                       start_pulse;
    logic [`ETH_DMA_DATA_W-1:0] dma_addr;
    logic [`ETH_DMA_LEN_W-1:0]  dma_len;
    logic                       busy;
    logic                       done_pulse;
    axi_resp_t                  done_resp;

    // host side
    eth_dma_apb_regs #(
        .no_small_transfer (no_small_transfer)
    ) u_regs (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .busy        (busy),
        .done_pulse  (done_pulse),
        .done_resp   (done_resp),
        .start_pulse (start_pulse),
        .dma_addr    (dma_addr),
        .dma_len     (dma_len)
    );

    // FIFO in, AXI out
    eth_dma_axi_writer #(
        .no_small_transfer (no_small_transfer)
    ) u_writer (
        .clk         (clk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .dma_addr    (dma_addr),
        .dma_len     (dma_len),
        .busy        (busy),
        .done_pulse  (done_pulse),
        .done_resp   (done_resp),
        .fifo_data   (fifo_data),
        .fifo_valid  (fifo_valid),
        .fifo_ready  (fifo_ready),
        .awaddr      (awaddr),
        .awlen       (awlen),
        .awsize      (awsize),
        .awburst     (awburst),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wlast       (wlast),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready)
    );

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
rtl/eth_dma_pkg.sv
rtl/eth_dma_apb_regs.sv
rtl/eth_burst_split.sv
rtl/eth_dma_axi_writer.sv
rtl/eth_dma_top.sv
verification/eth_dma_tb.sv

// ==== verification/eth_dma_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_dma_macros.svh"

module eth_dma_tb;
    localparam int num_xfers   = 20;
    localparam int cycle_limit = num_xfers * 300;
    localparam logic [31:0] page = 32'h2000_0000;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] fifo_data;
    logic        fifo_valid;
    logic        fifo_ready;
    logic [31:0] awaddr;
    logic [7:0]  awlen;
    logic [2:0]  awsize;
    logic [1:0]  awburst;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;

    // 4 KB memory page behind the AXI slave model
    logic [7:0]  mem [0:4095];
    logic [7:0]  frame [0:1023];
    logic [31:0] rng_main = 32'd52;
    logic [31:0] rng_bus = 32'd52;
    int          cycles = 0;
    int          err_count = 0;
    int          job_base = 0;
    int          job_len = 0;
    int          words_taken = 0;
    int          aw_count = 0;
    int          beat_count = 0;
    int          wlast_beat = -1;
    int          b_delay = 0;
    logic        b_pending = 1'b0;
    logic        inject_err = 1'b0;
    logic        w_early = 1'b0;
    logic [31:0] got_awaddr;
    logic [7:0]  got_awlen;
    logic [2:0]  got_awsize;
    logic [1:0]  got_awburst;

    eth_dma_top #(
        .no_small_transfer (1'b0)
    ) dut (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [7:0] fill_byte(input int idx);
        logic [11:0] a;
        a = idx[11:0];
        return (a[7:0] * 8'd29) ^ {a[11:8], a[11:8]} ^ 8'hC3;
    endfunction

    // frame bytes land at the start address, everything else keeps its fill
    function automatic logic [7:0] expected_byte(input int idx);
        if ((idx >= job_base) && (idx < job_base + job_len)) begin
            return frame[idx - job_base];
        end
        return fill_byte(idx);
    endfunction

    task automatic expect_true(input logic ok, input string msg);
        assert (ok) else begin
            err_count++;
            $display("ERR %0t ns: %s", $time, msg);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                            input logic err_exp, output logic [31:0] rdata);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        expect_true(pslverr == err_exp, $sformatf("pslverr %0b at offset 0x%03h, expected %0b",
                                                  pslverr, addr, err_exp));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic err_exp);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, err_exp, unused);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            input logic err_exp);
        apb_xfer(1'b0, addr, 32'h0, err_exp, data);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    // FIFO source, AXI slave and memory model
    // inputs change on the falling edge, handshakes are sampled 1 ns later
    initial begin : bus_model
        int idx;
        fifo_valid = 1'b0;
        fifo_data  = '0;
        awready    = 1'b0;
        wready     = 1'b0;
        bvalid     = 1'b0;
        bresp      = 2'b00;
        forever begin
            @(negedge clk);
            rng_bus    = lcg_step(rng_bus);
            fifo_valid = (rng_bus[19:16] != 4'd0);
            wready     = (rng_bus[23:20] != 4'd0);
            awready    = (rng_bus[25:24] != 2'd0);
            if (words_taken < 256) begin
                fifo_data = {frame[4*words_taken+3], frame[4*words_taken+2],
                             frame[4*words_taken+1], frame[4*words_taken]};
            end
            if (!b_pending) begin
                bvalid = 1'b0;
            end else if (b_delay == 0) begin
                bvalid = 1'b1;
                bresp  = inject_err ? 2'b10 : 2'b00;
            end else begin
                b_delay--;
            end
            #1;
            if (fifo_valid && fifo_ready) begin
                words_taken++;
            end
            if (awvalid && awready) begin
                aw_count++;
                got_awaddr  = awaddr;
                got_awlen   = awlen;
                got_awsize  = awsize;
                got_awburst = awburst;
            end
            if (wvalid && wready) begin
                if (aw_count == 0) begin
                    w_early = 1'b1;
                end
                for (int lane = 0; lane < 4; lane++) begin
                    idx = (int'(got_awaddr[11:0]) + 4 * beat_count + lane) % 4096;
                    if (wstrb[lane]) begin
                        mem[idx] = wdata[8*lane +: 8];
                    end
                end
                if (wlast && (wlast_beat < 0)) begin
                    wlast_beat = beat_count;
                    b_pending  = 1'b1;
                    b_delay    = int'(rng_bus[27:26]);
                end
                beat_count++;
            end
            if (bvalid && bready) begin
                b_pending = 1'b0;
            end
        end
    end

    initial begin : main_seq
        logic [31:0] rd;
        logic [31:0] exp_addr;
        int          off;
        int          max_len;
        int          first_bad;
        logic        mem_ok;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int t = 0; t < num_xfers; t++) begin
            // short frames first, then full length bursts, then random jobs
            rng_main = lcg_step(rng_main);
            off      = (t < 8) ? (t % 4) : int'(rng_main[17:16]);
            max_len  = (off == 0) ? 1023 : 1024 - off;
            if (t < 4) begin
                job_len = t + 1;
            end else if (t < 8) begin
                job_len = max_len;
            end else begin
                job_len = 1 + int'(rng_main[31:18]) % max_len;
            end
            rng_main   = lcg_step(rng_main);
            job_base   = 4 * (int'(rng_main[31:16]) % 768) + off;
            inject_err = (t % 5 == 3);
            for (int i = 0; i < 1024; i++) begin
                rng_main = lcg_step(rng_main);
                frame[i] = rng_main[23:16];
            end
            for (int i = 0; i < 4096; i++) begin
                mem[i] = fill_byte(i);
            end
            words_taken = 0;
            aw_count    = 0;
            beat_count  = 0;
            wlast_beat  = -1;
            w_early     = 1'b0;

            apb_write(`ETH_DMA_ADDR_REG, page + 32'(job_base), 1'b0);
            apb_write(`ETH_DMA_LEN_REG, 32'(job_len), 1'b0);
            apb_write(`ETH_DMA_CTRL_REG, 32'h1, 1'b0);
            if (t % 4 == 1) begin
                // engine is still on its burst here, so this start is refused
                apb_write(`ETH_DMA_CTRL_REG, 32'h1, 1'b1);
            end
            do begin
                apb_read(`ETH_DMA_STAT_REG, rd, 1'b0);
            end while (!rd[0]);

            exp_addr      = page + 32'(job_base);
            exp_addr[1:0] = 2'b00;
            expect_true(rd[2:1] == (inject_err ? 2'b10 : 2'b00),
                        $sformatf("job %0d status response %b", t, rd[2:1]));
            expect_true(!rd[3], $sformatf("job %0d still busy after done", t));
            expect_true(aw_count == 1, $sformatf("job %0d saw %0d AW handshakes", t, aw_count));
            expect_true(!w_early, $sformatf("job %0d data beat before address", t));
            expect_true(got_awaddr == exp_addr,
                        $sformatf("job %0d awaddr %h, expected %h", t, got_awaddr, exp_addr));
            expect_true(got_awlen == 8'((off + job_len + 3) / 4 - 1),
                        $sformatf("job %0d awlen %0d for offset %0d length %0d",
                                  t, got_awlen, off, job_len));
            expect_true((got_awsize == 3'd2) && (got_awburst == 2'b01),
                        $sformatf("job %0d awsize %0d awburst %0d", t, got_awsize, got_awburst));
            expect_true(beat_count == int'(got_awlen) + 1,
                        $sformatf("job %0d sent %0d beats", t, beat_count));
            expect_true(wlast_beat == int'(got_awlen),
                        $sformatf("job %0d wlast on beat %0d", t, wlast_beat));
            expect_true(words_taken == (job_len + 3) / 4,
                        $sformatf("job %0d took %0d FIFO words", t, words_taken));

            mem_ok    = 1'b1;
            first_bad = 0;
            for (int i = 4095; i >= 0; i--) begin
                if (mem[i] !== expected_byte(i)) begin
                    mem_ok    = 1'b0;
                    first_bad = i;
                end
            end
            expect_true(mem_ok, $sformatf("job %0d memory byte 0x%03h is %h, expected %h",
                                          t, first_bad, mem[first_bad], expected_byte(first_bad)));
        end

        // refused accesses with the engine idle
        aw_count = 0;
        apb_write(`ETH_DMA_LEN_REG, 32'h0, 1'b0);
        apb_write(`ETH_DMA_CTRL_REG, 32'h1, 1'b1);
        apb_read(12'h010, rd, 1'b1);
        apb_write(12'h020, 32'h1, 1'b1);
        repeat (4) @(negedge clk);
        expect_true((aw_count == 0) && !awvalid, "refused start produced AXI activity");
        apb_read(`ETH_DMA_STAT_REG, rd, 1'b0);
        expect_true(rd[0] && !rd[3], $sformatf("status %h after refused start", rd));

        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
